//--- Makefile
SIM        ?= verilator
TOP        ?= tb_mem_subsystem
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dcache.sv
`timescale 1ns/1ps

module dcache
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,

	// cpu request and response
	input logic dreq_valid,
	input addr_t dreq_addr,
	input strobe_t dreq_strobe,
	input word_t dreq_data,
	output logic dresp_data_ok,
	output word_t dresp_data,

	// memory bus request
	output logic creq_valid,
	output logic creq_is_write,
	output addr_t creq_addr,
	output strobe_t creq_strobe,
	output word_t creq_data,
	output mem_len_t creq_len,

	// memory bus response
	input logic cresp_ready,
	input logic cresp_last,
	input word_t cresp_data
);

	cache_state_t state, state_nxt;
	beat_t beat, beat_nxt;

	// address fields of the held request
	tag_t req_tag;
	index_t req_index;
	beat_t req_word;
	logic uncached;

	assign req_tag = dreq_addr[OFFSET_BITS+INDEX_BITS +: TAG_WIDTH];
	assign req_index = dreq_addr[OFFSET_BITS +: INDEX_BITS];
	assign req_word = dreq_addr[OFFSET_BITS-1:ALIGN_BITS];

	// cacheable only in the 0x8xxx_xxxx window of the low 4 GB
	assign uncached = dreq_addr[31:28] != CACHED_REGION || dreq_addr[63:32] != 32'd0;

	// tag RAM side
	logic [META_WIDTH-1:0] meta_rdata;
	logic [META_WIDTH-1:0] meta_wdata;
	logic meta_wen;
	logic meta_valid;
	tag_t meta_tag;
	logic hit;
	logic evict;

	assign meta_valid = meta_rdata[TAG_WIDTH];
	assign meta_tag = meta_rdata[TAG_WIDTH-1:0];
	// a fill always leaves the line valid under the new tag
	assign meta_wdata = {1'b1, req_tag};

	assign hit = meta_valid && meta_tag == req_tag;
	// no dirty bit, so any valid line of another tag goes back
	assign evict = meta_valid && meta_tag != req_tag;

	// data RAM side
	data_addr_t data_addr;
	strobe_t data_wen;
	word_t data_rdata;
	word_t data_wdata;

	// cpu offset on lookup and beat counter during a burst
	assign data_addr = (state == IDLE) ? {req_index, req_word} : {req_index, beat};
	assign data_wdata = (state == FETCH) ? cresp_data : dreq_data;

	always_comb begin
		state_nxt = state;
		beat_nxt = beat;
		data_wen = '0;
		meta_wen = 1'b0;
		unique case (state)
			IDLE: begin
				if (dreq_valid) begin
					if (uncached) begin
						state_nxt = UNCACHED;
					end else if (hit) begin
						// write hit lands at this edge
						data_wen = dreq_strobe;
					end else if (evict) begin
						state_nxt = WRITEBACK;
					end else begin
						state_nxt = FETCH;
					end
				end
			end
			FETCH: begin
				if (cresp_ready) begin
					data_wen = '1;
					meta_wen = 1'b1;
					// counter wraps to zero on the sixteenth beat
					beat_nxt = beat + 1'b1;
					if (cresp_last) begin
						// retried lookup hits back in IDLE
						state_nxt = IDLE;
					end
				end
			end
			WRITEBACK: begin
				if (cresp_ready) begin
					beat_nxt = beat + 1'b1;
					if (cresp_last) begin
						state_nxt = FETCH;
					end
				end
			end
			UNCACHED: begin
				// single beat with ready and last together
				if (cresp_ready) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			beat <= '0;
		end else begin
			state <= state_nxt;
			beat <= beat_nxt;
		end
	end

	// hits answer in the same cycle and uncached accesses on the memory beat
	assign dresp_data_ok = dreq_valid && (uncached ? (state == UNCACHED && cresp_ready)
		: (state == IDLE && hit));
	assign dresp_data = uncached ? cresp_data : data_rdata;

	// request held for the whole transaction
	assign creq_valid = state != IDLE;
	assign creq_is_write = (state == UNCACHED && |dreq_strobe) || state == WRITEBACK;
	assign creq_strobe = (state == UNCACHED) ? dreq_strobe : '1;
	assign creq_data = (state == UNCACHED) ? dreq_data : data_rdata;
	assign creq_len = (state == UNCACHED) ? LEN_SINGLE : LEN_LINE;

	// victim address rebuilt from the stored tag
	always_comb begin
		unique case (state)
			UNCACHED: creq_addr = dreq_addr;
			WRITEBACK: creq_addr = {32'd0, CACHED_REGION, meta_tag, req_index, {OFFSET_BITS{1'b0}}};
			default: creq_addr = {dreq_addr[63:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		endcase
	end

	// per-line valid bit and tag that the reset sweep clears
	ram_single_port #(
		.ADDR_WIDTH(INDEX_BITS),
		.DATA_WIDTH(META_WIDTH),
		.BYTE_WIDTH(META_WIDTH),
		.CLEAR_ON_RESET(1'b1)
	) meta_ram (
		.clk(clk),
		.reset(reset),
		.addr(req_index),
		.strobe(meta_wen),
		.wdata(meta_wdata),
		.rdata(meta_rdata)
	);

	// 256 byte-writable words
	ram_single_port #(
		.ADDR_WIDTH($bits(data_addr_t)),
		.DATA_WIDTH($bits(word_t)),
		.BYTE_WIDTH(8),
		.CLEAR_ON_RESET(1'b0)
	) data_ram (
		.clk(clk),
		.reset(reset),
		.addr(data_addr),
		.strobe(data_wen),
		.wdata(data_wdata),
		.rdata(data_rdata)
	);

	// memory must not see the request vanish mid burst
	a_creq_held: assert property (
		@(posedge clk) disable iff (reset)
		(creq_valid && !(cresp_ready && cresp_last)) |=> creq_valid
	);

	// every burst leaves the counter back at zero
	a_beat_idle_zero: assert property (
		@(posedge clk) disable iff (reset) state == IDLE |-> beat == '0
	);

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

	// byte address and data word on both buses
	typedef logic [63:0] addr_t;
	typedef logic [63:0] word_t;

	// one enable per byte of a word
	typedef logic [7:0] strobe_t;

	// byte offset inside a 64-bit word
	localparam int ALIGN_BITS = 3;

	// 128-byte lines
	localparam int OFFSET_BITS = 7;
	localparam int WORDS_PER_LINE = 16;

	// 16 lines, 2 KB total
	localparam int INDEX_BITS = 4;

	// tag covers address bits 27 down to the index
	localparam int TAG_WIDTH = 28 - OFFSET_BITS - INDEX_BITS;

	// valid bit on top of the tag
	localparam int META_WIDTH = TAG_WIDTH + 1;

	// bits 31..28 of a cacheable address
	localparam logic [3:0] CACHED_REGION = 4'h8;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	// word position within a line
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] beat_t;

	// data RAM word address, index above beat
	typedef logic [INDEX_BITS+OFFSET_BITS-ALIGN_BITS-1:0] data_addr_t;

	// beats minus one, as seen on the memory bus
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] mem_len_t;

	localparam mem_len_t LEN_LINE = mem_len_t'(WORDS_PER_LINE - 1);
	localparam mem_len_t LEN_SINGLE = '0;

	// main memory only decodes 16 KB
	localparam int MEM_ADDR_BITS = 14;

	// word address inside main memory
	typedef logic [MEM_ADDR_BITS-ALIGN_BITS-1:0] mem_word_addr_t;

	// cache controller states
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		WRITEBACK,
		UNCACHED
	} cache_state_t;

endpackage

//--- filelist.f
dcache_pkg.sv
ram_single_port.sv
dcache.sv
main_mem.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- main_mem.sv
`timescale 1ns/1ps

module main_mem
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,

	// request from the cache
	input logic creq_valid,
	input logic creq_is_write,
	input addr_t creq_addr,
	input strobe_t creq_strobe,
	input word_t creq_data,
	input mem_len_t creq_len,

	// per-beat response
	output logic cresp_ready,
	output logic cresp_last,
	output word_t cresp_data
);

	// idle, one beat per cycle, then a dead cycle
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_RESPOND,
		MEM_GAP
	} mem_phase_t;

	mem_phase_t phase;
	mem_len_t beat;

	// captured when the request is accepted
	mem_word_addr_t start_word;
	mem_len_t len;

	mem_word_addr_t cur_word;
	strobe_t ram_wen;
	logic final_beat;

	assign final_beat = beat == len;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= MEM_IDLE;
			beat <= '0;
		end else begin
			unique case (phase)
				MEM_IDLE: begin
					if (creq_valid) begin
						phase <= MEM_RESPOND;
						beat <= '0;
					end
				end
				MEM_RESPOND: begin
					if (final_beat) begin
						phase <= MEM_GAP;
						beat <= '0;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				MEM_GAP: begin
					// next request sampled only from idle
					phase <= MEM_IDLE;
				end
				default: begin
					phase <= MEM_IDLE;
				end
			endcase
		end
	end

	// start word and length only, the rest is held by the cache
	always_ff @(posedge clk) begin
		if (phase == MEM_IDLE && creq_valid) begin
			start_word <= creq_addr[MEM_ADDR_BITS-1:ALIGN_BITS];
			len <= creq_len;
		end
	end

	// incrementing burst, line bursts never cross the end
	assign cur_word = start_word + mem_word_addr_t'(beat);

	assign cresp_ready = phase == MEM_RESPOND;
	assign cresp_last = phase == MEM_RESPOND && final_beat;

	// write beats take the cache data under its strobe
	assign ram_wen = (phase == MEM_RESPOND && creq_is_write) ? creq_strobe : '0;

	ram_single_port #(
		.ADDR_WIDTH($bits(mem_word_addr_t)),
		.DATA_WIDTH($bits(word_t)),
		.BYTE_WIDTH(8),
		.CLEAR_ON_RESET(1'b0)
	) i_ram (
		.clk(clk),
		.reset(reset),
		.addr(cur_word),
		.strobe(ram_wen),
		.wdata(creq_data),
		.rdata(cresp_data)
	);

	// a beat only answers a live request
	a_ready_needs_valid: assert property (
		@(posedge clk) disable iff (reset) cresp_ready |-> creq_valid
	);

endmodule

//--- mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,

	// cpu side
	input logic dreq_valid,
	input addr_t dreq_addr,
	input strobe_t dreq_strobe,
	input word_t dreq_data,
	output logic dresp_data_ok,
	output word_t dresp_data
);

	// memory bus between cache and main memory
	logic creq_valid;
	logic creq_is_write;
	addr_t creq_addr;
	strobe_t creq_strobe;
	word_t creq_data;
	mem_len_t creq_len;
	logic cresp_ready;
	logic cresp_last;
	word_t cresp_data;

	dcache i_dcache (
		.clk(clk),
		.reset(reset),
		.dreq_valid(dreq_valid),
		.dreq_addr(dreq_addr),
		.dreq_strobe(dreq_strobe),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data),
		.creq_valid(creq_valid),
		.creq_is_write(creq_is_write),
		.creq_addr(creq_addr),
		.creq_strobe(creq_strobe),
		.creq_data(creq_data),
		.creq_len(creq_len),
		.cresp_ready(cresp_ready),
		.cresp_last(cresp_last),
		.cresp_data(cresp_data)
	);

	main_mem i_main_mem (
		.clk(clk),
		.reset(reset),
		.creq_valid(creq_valid),
		.creq_is_write(creq_is_write),
		.creq_addr(creq_addr),
		.creq_strobe(creq_strobe),
		.creq_data(creq_data),
		.creq_len(creq_len),
		.cresp_ready(cresp_ready),
		.cresp_last(cresp_last),
		.cresp_data(cresp_data)
	);

endmodule

//--- ram_single_port.sv
`timescale 1ns/1ps

module ram_single_port #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 64,
	parameter int BYTE_WIDTH = 8,
	parameter bit CLEAR_ON_RESET = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic [ADDR_WIDTH-1:0] addr,
	input logic [DATA_WIDTH/BYTE_WIDTH-1:0] strobe,
	input logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata
);

	// contents start at zero in simulation
	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH] = '{default: '0};

	// clearing sweep, one entry per cycle after reset
	logic sweep_active;
	logic [ADDR_WIDTH-1:0] sweep_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			sweep_active <= CLEAR_ON_RESET;
			sweep_addr <= '0;
		end else if (sweep_active) begin
			sweep_addr <= sweep_addr + 1'b1;
			// last entry cleared, sweep done
			if (sweep_addr == '1) begin
				sweep_active <= 1'b0;
			end
		end
	end

	// sweep owns the write port while it runs
	always_ff @(posedge clk) begin
		if (sweep_active) begin
			mem[sweep_addr] <= '0;
		end else begin
			for (int i = 0; i < DATA_WIDTH / BYTE_WIDTH; i++) begin
				if (strobe[i]) begin
					mem[addr][i*BYTE_WIDTH +: BYTE_WIDTH] <= wdata[i*BYTE_WIDTH +: BYTE_WIDTH];
				end
			end
		end
	end

	// read has no latency
	assign rdata = mem[addr];

	// users must wait for the sweep before writing
	a_no_write_during_sweep: assert property (
		@(posedge clk) disable iff (reset) sweep_active |-> strobe == '0
	);

endmodule

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
	import dcache_pkg::*;
();

	localparam int CLK_HALF = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT = 200;
	localparam int MODEL_WORDS = 2048;

	logic clk;
	logic reset;
	logic dreq_valid;
	addr_t dreq_addr;
	strobe_t dreq_strobe;
	word_t dreq_data;
	logic dresp_data_ok;
	word_t dresp_data;

	// flat image of main memory as the cpu sees it, bits 13..3
	word_t model [MODEL_WORDS];

	mem_subsystem i_mem_subsystem (
		.clk(clk),
		.reset(reset),
		.dreq_valid(dreq_valid),
		.dreq_addr(dreq_addr),
		.dreq_strobe(dreq_strobe),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// new bytes replace old ones under the strobe
	function automatic word_t merge_bytes(word_t old_word, word_t new_word, strobe_t strb);
		word_t merged;
		merged = old_word;
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	function automatic int model_index(addr_t addr);
		return int'(addr[13:3]);
	endfunction

	// lower 8 KB of memory, through the cache
	function automatic addr_t cached_addr(int unsigned word);
		return 64'h8000_0000 + (addr_t'(word & 32'h3ff) << 3);
	endfunction

	// upper 8 KB, single beats
	function automatic addr_t uncached_addr(int unsigned word);
		return 64'h4000_2000 + (addr_t'(word & 32'h3ff) << 3);
	endfunction

	function automatic word_t random_word();
		return {$urandom, $urandom};
	endfunction

	// never zero, zero would be a read
	function automatic strobe_t random_strobe();
		strobe_t strb;
		strb = strobe_t'($urandom);
		if (strb == '0) begin
			strb = 8'hff;
		end
		return strb;
	endfunction

	// 30% uncached, half the cached ones on three hot lines
	function automatic addr_t mixed_addr();
		int unsigned w;
		w = $urandom;
		if ($urandom_range(99) < 30) begin
			return uncached_addr(w);
		end
		if ($urandom_range(1) == 1) begin
			// word bits 7..4 are the cache index
			case ($urandom_range(2))
				0: w[7:4] = 4'h3;
				1: w[7:4] = 4'h9;
				default: w[7:4] = 4'hc;
			endcase
		end
		return cached_addr(w);
	endfunction

	// one request held until data_ok, entered and left 1 ns after an edge
	task automatic cpu_access(input addr_t addr, input strobe_t strb, input word_t wdata,
		output word_t rdata, output int waited);
		int cycles;
		cycles = 0;
		dreq_valid = 1'b1;
		dreq_addr = addr;
		dreq_strobe = strb;
		dreq_data = wdata;
		// combinational response is settled by the falling edge
		@(negedge clk);
		while (!dresp_data_ok) begin
			if (cycles >= TIMEOUT) begin
				$display("no dresp_data_ok within %0d cycles for address %h", TIMEOUT, addr);
				$display("Verification failed");
				$fatal(1, "request timed out");
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
		rdata = dresp_data;
		waited = cycles;
		// handshake taken at this edge
		@(posedge clk);
		#DRIVE_DELAY;
		dreq_valid = 1'b0;
		if (strb != '0) begin
			model[model_index(addr)] = merge_bytes(model[model_index(addr)], wdata, strb);
		end
	endtask

	task automatic write_word(input addr_t addr, input strobe_t strb, input word_t wdata);
		word_t unused_data;
		int unused_wait;
		cpu_access(addr, strb, wdata, unused_data, unused_wait);
	endtask

	task automatic read_check(input addr_t addr, output int waited);
		word_t got;
		word_t expected;
		expected = model[model_index(addr)];
		cpu_access(addr, '0, '0, got, waited);
		assert (got === expected) else begin
			$display("error: at %0t addr %h expected %h actual %h", $time, addr, expected, got);
			$display("Verification failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	initial begin
		addr_t a;
		addr_t b;
		int waited;
		void'($urandom(32'h3092));
		reset = 1'b1;
		dreq_valid = 1'b0;
		dreq_addr = '0;
		dreq_strobe = '0;
		dreq_data = '0;
		// main memory powers up at zero
		for (int i = 0; i < MODEL_WORDS; i++) begin
			model[i] = '0;
		end
		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		// tag RAM clears one entry per cycle
		repeat (16) @(posedge clk);
		#DRIVE_DELAY;

		// cold miss reads zero
		read_check(cached_addr($urandom), waited);

		// cached write then read back
		repeat (20) begin
			a = cached_addr($urandom);
			write_word(a, random_strobe(), random_word());
			read_check(a, waited);
		end

		// bit 11 sits in the tag, same index, forces writeback and refill
		repeat (10) begin
			a = cached_addr($urandom);
			b = a ^ 64'h800;
			write_word(a, random_strobe(), random_word());
			read_check(b, waited);
			write_word(b, random_strobe(), random_word());
			read_check(a, waited);
			read_check(b, waited);
		end

		// uncached window
		repeat (30) begin
			a = uncached_addr($urandom);
			write_word(a, random_strobe(), random_word());
			read_check(a, waited);
			read_check(uncached_addr($urandom), waited);
		end

		// mixed traffic, 40% writes
		for (int n = 0; n < 3000; n++) begin
			a = mixed_addr();
			if ($urandom_range(99) < 40) begin
				write_word(a, random_strobe(), random_word());
			end else begin
				read_check(a, waited);
			end
		end

		// repeat read must hit with no wait
		repeat (10) begin
			a = cached_addr($urandom);
			read_check(a, waited);
			read_check(a, waited);
			assert (waited == 0) else begin
				$display("error: at %0t hit on %h waited %0d cycles instead of none",
					$time, a, waited);
				$display("Verification failed");
				$fatal(1, "hit was not answered in the first cycle");
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule
